// ==== design/lpbk_cfg.svh ====
// Loopback engine configuration
`ifndef LPBK_CFG_SVH
`define LPBK_CFG_SVH

// **************************************************
// address layout
// **************************************************
`define LPBK_ADDR_W      20                      // line address width
`define LPBK_OWN_BIT     10                      // 1 fpga owned, 0 cpu owned

// line index starts at the ownership bit
`define LPBK_LINES_LOG2  3                       // index bits
`define LPBK_LINES       8                       // lines walked by the engine

// **************************************************
// request and data widths
// **************************************************
`define LPBK_TAG_W       8                       // request tag
`define LPBK_WORD_W      32                      // one data word
`define LPBK_LINE_W      128                     // four words per line

`define LPBK_SEED_INIT   8'h01                   // lfsr start value, never zero

`endif

// ==== design/lpbk_bus_pkg.sv ====
// Memory-side request and response types
package lpbk_bus_pkg;

`include "lpbk_cfg.svh"

    typedef logic [`LPBK_ADDR_W-1:0] addr_t;     // line address
    typedef logic [`LPBK_TAG_W-1:0]  tag_t;      // request tag
    typedef logic [`LPBK_WORD_W-1:0] word_t;     // one data word
    typedef logic [`LPBK_LINE_W-1:0] line_t;     // {word3, word2, word1, word0}
    typedef logic [7:0]              seed_t;     // pseudo-random seed byte

    // **************************************************
    // requests towards memory
    // **************************************************
    typedef struct packed {
        logic  en;                               // request offered
        addr_t addr;
        tag_t  tag;                              // line index
        line_t data;                             // write payload
    } wr_req_t;

    typedef struct packed {
        logic  en;                               // request offered
        addr_t addr;
        tag_t  tag;
    } rd_req_t;

    // responses, one cycle pulses
    typedef struct packed {
        logic  valid;
        addr_t addr;
        line_t data;                             // returned line
    } rd_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } wr_rsp_t;

endpackage

// ==== design/lpbk_test_pkg.sv ====
// Test control and error record types
package lpbk_test_pkg;

`include "lpbk_cfg.svh"

    typedef logic [`LPBK_LINES_LOG2-1:0] line_idx_t;   // line index
    typedef logic [`LPBK_LINES_LOG2:0]   line_cnt_t;   // configured line count
    typedef logic [5:0]                  err_code_t;

    // per-line request fsm
    typedef enum logic [1:0] {
        rd_pend = 2'h0,                          // read out, waiting on response
        wr_pend = 2'h1,                          // write out, waiting on response
        send_rd = 2'h2,
        send_wr = 2'h3
    } line_state_e;

    localparam err_code_t err_line_cnt = 6'b100000;   // fewer than 2 lines
    localparam err_code_t err_fpga_own = 6'b001000;   // fpga owned line mismatch
    localparam err_code_t err_cpu_own  = 6'b011000;   // cpu owned line mismatch

    typedef struct packed {
        logic                go;                 // level, issue while high
        lpbk_bus_pkg::word_t dst_addr;           // xor key for address words
        line_cnt_t           num_lines;
    } test_cfg_t;

    typedef struct packed {
        logic                valid;              // sticky
        err_code_t           code;
        lpbk_bus_pkg::word_t addr;               // expected address word
        lpbk_bus_pkg::word_t received;
        lpbk_bus_pkg::word_t expected;
    } err_info_t;

endpackage

// ==== design/line_tracker.sv ====
// Per-line request state machines
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module line_tracker (
    input  logic                     Clk_16UI,
    input  logic                     arst_n,
    input  lpbk_test_pkg::line_idx_t rd_idx,        // line the read counter examines
    input  lpbk_test_pkg::line_idx_t wr_idx,        // line the write counter examines
    output logic                     rd_ready,
    output logic                     wr_ready,
    input  lpbk_bus_pkg::wr_req_t    wr_req,
    input  logic                     wr_sent,
    input  lpbk_bus_pkg::rd_req_t    rd_req,
    input  logic                     rd_sent,
    input  logic                     rd_rsp_valid,
    input  lpbk_bus_pkg::addr_t      rd_rsp_addr,
    input  logic                     wr_rsp_valid,
    input  lpbk_bus_pkg::addr_t      wr_rsp_addr
);

    lpbk_test_pkg::line_state_e state_q [`LPBK_LINES];
    logic [`LPBK_LINES-1:0]     sent;               // accepted this cycle
    logic [`LPBK_LINES-1:0]     cmp_d;              // response seen this cycle
    logic [`LPBK_LINES-1:0]     cmp_q;              // completion, one cycle later

    // **************************************************
    // sent and complete decoding
    // **************************************************
    always_comb
    begin
        sent  = '0;
        cmp_d = '0;
        if (wr_req.en && wr_sent)
            sent[wr_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]] = 1'b1;
        if (rd_req.en && rd_sent)
            sent[rd_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]] = 1'b1;
        if (rd_rsp_valid)
            cmp_d[rd_rsp_addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]] = 1'b1;
        if (wr_rsp_valid)
            cmp_d[wr_rsp_addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]] = 1'b1;
    end

    // a line accepted right now is still in its send state, so mask it
    assign rd_ready = (state_q[rd_idx] == lpbk_test_pkg::send_rd) && !sent[rd_idx];
    assign wr_ready = (state_q[wr_idx] == lpbk_test_pkg::send_wr) && !sent[wr_idx];

    // **************************************************
    // line state machines
    // **************************************************
    always_ff @(posedge Clk_16UI or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cmp_q <= '0;
            for (int i = 0; i < `LPBK_LINES; i++)
                state_q[i] <= i[0] ? lpbk_test_pkg::send_wr : lpbk_test_pkg::send_rd;
        end
        else
        begin
            cmp_q <= cmp_d;
            for (int i = 0; i < `LPBK_LINES; i++)
            begin
                case (state_q[i])
                    lpbk_test_pkg::send_rd:
                        if (sent[i])
                            state_q[i] <= lpbk_test_pkg::rd_pend;
                    lpbk_test_pkg::send_wr:
                        if (sent[i])
                            state_q[i] <= lpbk_test_pkg::wr_pend;
                    lpbk_test_pkg::rd_pend:                 // odd lines write next
                        if (cmp_q[i])
                            state_q[i] <= i[0] ? lpbk_test_pkg::send_wr
                                               : lpbk_test_pkg::send_rd;
                    default:                                // wr_pend, read back next
                        if (cmp_q[i])
                            state_q[i] <= lpbk_test_pkg::send_rd;
                endcase
            end
        end
    end

endmodule

// ==== design/req_issuer.sv ====
// Read and write request issue
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module req_issuer (
    input  logic                     Clk_16UI,
    input  logic                     arst_n,
    input  lpbk_test_pkg::test_cfg_t cfg,
    input  logic                     rd_ready,      // examined read line in send_rd
    input  logic                     wr_ready,      // examined write line in send_wr
    output lpbk_test_pkg::line_idx_t rd_idx,
    output lpbk_test_pkg::line_idx_t wr_idx,
    output lpbk_bus_pkg::wr_req_t    wr_req,
    output lpbk_bus_pkg::rd_req_t    rd_req,
    output logic                     seed_we,
    output lpbk_test_pkg::line_idx_t seed_waddr,
    output lpbk_bus_pkg::seed_t      seed_wdata
);

    lpbk_test_pkg::line_idx_t rd_cnt;
    lpbk_test_pkg::line_idx_t wr_cnt;               // odd lines only
    lpbk_test_pkg::line_cnt_t last_line;
    lpbk_bus_pkg::addr_t      rd_addr;
    lpbk_bus_pkg::addr_t      wr_addr;
    lpbk_bus_pkg::word_t      addr_word;            // word0 and word2 of the write
    lpbk_bus_pkg::seed_t      lfsr;

    assign last_line = cfg.num_lines - lpbk_test_pkg::line_cnt_t'(1);
    assign rd_addr   = lpbk_bus_pkg::addr_t'(rd_cnt) << `LPBK_OWN_BIT;
    assign wr_addr   = lpbk_bus_pkg::addr_t'(wr_cnt) << `LPBK_OWN_BIT;
    assign addr_word = cfg.dst_addr ^ lpbk_bus_pkg::word_t'(wr_addr);

    assign rd_idx = rd_cnt;
    assign wr_idx = wr_cnt;

    // **************************************************
    // counters, lfsr and registered requests
    // **************************************************
    always_ff @(posedge Clk_16UI or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_cnt <= '0;
            wr_cnt <= lpbk_test_pkg::line_idx_t'(1);    // first odd line
            lfsr   <= `LPBK_SEED_INIT;
            wr_req <= '0;
            rd_req <= '0;
        end
        else
        begin
            lfsr <= {lfsr[6:0], lfsr[3] ^ lfsr[4] ^ lfsr[5] ^ lfsr[7]};

            wr_req.addr <= wr_addr;
            wr_req.tag  <= lpbk_bus_pkg::tag_t'(wr_cnt);
            wr_req.data <= {{4{~lfsr}}, addr_word, {4{lfsr}}, addr_word};
            rd_req.addr <= rd_addr;
            rd_req.tag  <= lpbk_bus_pkg::tag_t'(rd_cnt);

            if (cfg.go)
            begin
                wr_req.en <= wr_ready;
                rd_req.en <= rd_ready;

                if (lpbk_test_pkg::line_cnt_t'(rd_cnt) < last_line) // every line
                    rd_cnt <= rd_cnt + lpbk_test_pkg::line_idx_t'(1);
                else
                    rd_cnt <= '0;

                if (lpbk_test_pkg::line_cnt_t'(wr_cnt) < last_line) // step over even lines
                    wr_cnt <= wr_cnt + lpbk_test_pkg::line_idx_t'(2);
                else
                    wr_cnt <= lpbk_test_pkg::line_idx_t'(1);
            end
            else
            begin
                wr_req.en <= 1'b0;
                rd_req.en <= 1'b0;
            end
        end
    end

    // seed of the offered write, low byte of word1
    assign seed_we    = wr_req.en;
    assign seed_waddr = wr_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2];
    assign seed_wdata = wr_req.data[`LPBK_WORD_W +: $bits(lpbk_bus_pkg::seed_t)];

endmodule

// ==== design/seed_ram.sv ====
// Per-line seed memory
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module seed_ram (
    input  logic                     Clk_16UI,
    input  logic                     we,
    input  lpbk_test_pkg::line_idx_t waddr,
    input  lpbk_bus_pkg::seed_t      wdata,
    input  lpbk_test_pkg::line_idx_t raddr,
    output lpbk_bus_pkg::seed_t      rdata          // one cycle after raddr
);

    lpbk_bus_pkg::seed_t mem [`LPBK_LINES];

    // write port
    always_ff @(posedge Clk_16UI)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge Clk_16UI)
    begin
        rdata <= mem[raddr];
    end

endmodule

// ==== design/rd_checker.sv ====
// Read response check and error record
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module rd_checker (
    input  logic                     Clk_16UI,
    input  logic                     arst_n,
    input  lpbk_test_pkg::test_cfg_t cfg,
    input  lpbk_bus_pkg::rd_rsp_t    rd_rsp,
    output lpbk_test_pkg::line_idx_t seed_raddr,
    input  lpbk_bus_pkg::seed_t      seed_rdata,    // seed of the registered response
    output lpbk_test_pkg::err_info_t err
);

    logic                     rsp_valid_q;
    lpbk_bus_pkg::addr_t      rsp_addr_q;
    lpbk_bus_pkg::line_t      rsp_data_q;
    lpbk_bus_pkg::word_t      exp_addr_q;           // dst_addr xor line address
    lpbk_bus_pkg::word_t      seed_word;
    lpbk_bus_pkg::word_t      word [4];
    lpbk_bus_pkg::word_t      rcv_word;
    lpbk_bus_pkg::word_t      exp_word;
    logic                     mismatch;
    lpbk_test_pkg::err_code_t chk_code;

    assign seed_raddr = rd_rsp.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2];  // ram lines up with _q
    assign seed_word  = {4{seed_rdata}};

    always_ff @(posedge Clk_16UI or negedge arst_n)
    begin
        if (!arst_n)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= rd_rsp.valid;
    end

    always_ff @(posedge Clk_16UI)
    begin
        rsp_addr_q <= rd_rsp.addr;
        rsp_data_q <= rd_rsp.data;
        exp_addr_q <= cfg.dst_addr ^ lpbk_bus_pkg::word_t'(rd_rsp.addr);
    end

    // **************************************************
    // word compare, first difference wins
    // **************************************************
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            word[i] = rsp_data_q[i*`LPBK_WORD_W +: `LPBK_WORD_W];
        mismatch = 1'b1;
        rcv_word = '0;
        exp_word = '0;
        chk_code = rsp_addr_q[`LPBK_OWN_BIT] ? lpbk_test_pkg::err_fpga_own
                                              : lpbk_test_pkg::err_cpu_own;
        if (rsp_addr_q[`LPBK_OWN_BIT] && word[1] != seed_word)
        begin
            rcv_word = word[1];                     // seed byte x4
            exp_word = seed_word;
        end
        else if (rsp_addr_q[`LPBK_OWN_BIT] && word[3] != ~seed_word)
        begin
            rcv_word = word[3];                     // inverted seed x4
            exp_word = ~seed_word;
        end
        else if (word[0] != exp_addr_q)
        begin
            rcv_word = word[0];
            exp_word = exp_addr_q;
        end
        else if (word[2] != exp_addr_q)
        begin
            rcv_word = word[2];
            exp_word = exp_addr_q;
        end
        else
            mismatch = 1'b0;
    end

    // sticky error record
    always_ff @(posedge Clk_16UI or negedge arst_n)
    begin
        if (!arst_n)
            err <= '0;
        else if (!err.valid)
        begin
            if (cfg.go && cfg.num_lines <= lpbk_test_pkg::line_cnt_t'(1))
            begin
                err.valid <= 1'b1;                  // too few lines to walk
                err.code  <= lpbk_test_pkg::err_line_cnt;
            end
            else if (rsp_valid_q && mismatch)
            begin
                err.valid    <= 1'b1;
                err.code     <= chk_code;
                err.addr     <= exp_addr_q;
                err.received <= rcv_word;
                err.expected <= exp_word;
            end
        end
    end

endmodule

// ==== design/lpbk_coherency.sv ====
// Cache coherency loopback engine
`timescale 1ns/100ps

module lpbk_coherency (
    input  logic                     Clk_16UI,
    input  logic                     arst_n,
    input  lpbk_test_pkg::test_cfg_t cfg,
    output lpbk_bus_pkg::wr_req_t    wr_req,
    input  logic                     wr_sent,       // write accepted
    output lpbk_bus_pkg::rd_req_t    rd_req,
    input  logic                     rd_sent,       // read accepted
    input  lpbk_bus_pkg::rd_rsp_t    rd_rsp,
    input  lpbk_bus_pkg::wr_rsp_t    wr_rsp,
    output lpbk_test_pkg::err_info_t err
);

    lpbk_test_pkg::line_idx_t rd_idx;
    lpbk_test_pkg::line_idx_t wr_idx;
    logic                     rd_ready;
    logic                     wr_ready;
    logic                     seed_we;
    lpbk_test_pkg::line_idx_t seed_waddr;
    lpbk_bus_pkg::seed_t      seed_wdata;
    lpbk_test_pkg::line_idx_t seed_raddr;
    lpbk_bus_pkg::seed_t      seed_rdata;

    // **************************************************
    // line states
    // **************************************************
    line_tracker i_line_tracker (
        .Clk_16UI     (Clk_16UI),
        .arst_n       (arst_n),
        .rd_idx       (rd_idx),
        .wr_idx       (wr_idx),
        .rd_ready     (rd_ready),
        .wr_ready     (wr_ready),
        .wr_req       (wr_req),
        .wr_sent      (wr_sent),
        .rd_req       (rd_req),
        .rd_sent      (rd_sent),
        .rd_rsp_valid (rd_rsp.valid),
        .rd_rsp_addr  (rd_rsp.addr),
        .wr_rsp_valid (wr_rsp.valid),
        .wr_rsp_addr  (wr_rsp.addr)
    );

    req_issuer i_req_issuer (
        .Clk_16UI   (Clk_16UI),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .rd_ready   (rd_ready),
        .wr_ready   (wr_ready),
        .rd_idx     (rd_idx),
        .wr_idx     (wr_idx),
        .wr_req     (wr_req),
        .rd_req     (rd_req),
        .seed_we    (seed_we),
        .seed_waddr (seed_waddr),
        .seed_wdata (seed_wdata)
    );

    // seed of the last write per line
    seed_ram i_seed_ram (
        .Clk_16UI (Clk_16UI),
        .we       (seed_we),
        .waddr    (seed_waddr),
        .wdata    (seed_wdata),
        .raddr    (seed_raddr),
        .rdata    (seed_rdata)
    );

    rd_checker i_rd_checker (
        .Clk_16UI   (Clk_16UI),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .rd_rsp     (rd_rsp),
        .seed_raddr (seed_raddr),
        .seed_rdata (seed_rdata),
        .err        (err)
    );

endmodule

// ==== test/lpbk_coherency_chk.sv ====
// Loopback engine assertions
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module lpbk_coherency_chk (
    input logic                     Clk_16UI,
    input logic                     arst_n,
    input lpbk_bus_pkg::wr_req_t    wr_req,
    input logic                     wr_sent,
    input lpbk_bus_pkg::rd_req_t    rd_req,
    input logic                     rd_sent,
    input lpbk_test_pkg::err_info_t err
);

    int   assert_fails = 0;                         // summed into the run total
    logic wr_acc;
    logic rd_acc;

    assign wr_acc = wr_req.en && wr_sent;           // write accepted
    assign rd_acc = rd_req.en && rd_sent;

    // writes only target fpga owned lines
    wr_owned: assert property (@(posedge Clk_16UI) disable iff (!arst_n)
        wr_acc |-> wr_req.addr[`LPBK_OWN_BIT])
    else
    begin
        $error("accepted write to a cpu owned line");
        assert_fails++;
    end

    // sticky error record
    err_sticky: assert property (@(posedge Clk_16UI) disable iff (!arst_n)
        err.valid |=> err.valid)
    else
    begin
        $error("error record dropped without reset");
        assert_fails++;
    end

    // one request per line at a time
    no_rd_wr_same_line: assert property (@(posedge Clk_16UI) disable iff (!arst_n)
        (wr_acc && rd_acc) |-> (wr_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]
                                != rd_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2]))
    else
    begin
        $error("line read and written in the same cycle");
        assert_fails++;
    end

endmodule

bind lpbk_coherency lpbk_coherency_chk i_lpbk_coherency_chk (
    .Clk_16UI (Clk_16UI),
    .arst_n   (arst_n),
    .wr_req   (wr_req),
    .wr_sent  (wr_sent),
    .rd_req   (rd_req),
    .rd_sent  (rd_sent),
    .err      (err)
);

// ==== test/tb_lpbk_coherency.sv ====
// Loopback engine testbench
`timescale 1ns/100ps

`include "lpbk_cfg.svh"

module tb_lpbk_coherency;

    localparam int max_cycles = 5 * 400;            // five tests, 400 cycles each at most

    logic                     Clk_16UI;
    logic                     arst_n;
    lpbk_test_pkg::test_cfg_t cfg;
    lpbk_bus_pkg::wr_req_t    wr_req;
    logic                     wr_sent;
    lpbk_bus_pkg::rd_req_t    rd_req;
    logic                     rd_sent;
    lpbk_bus_pkg::rd_rsp_t    rd_rsp;
    lpbk_bus_pkg::wr_rsp_t    wr_rsp;
    lpbk_test_pkg::err_info_t err;

    lpbk_bus_pkg::line_t      mem [`LPBK_LINES];    // memory model lines
    lpbk_bus_pkg::seed_t      seed_rec [`LPBK_LINES]; // seed of last accepted write
    lpbk_bus_pkg::rd_rsp_t    rd_pipe [2];          // response delay stages
    lpbk_bus_pkg::wr_rsp_t    wr_pipe [2];
    lpbk_test_pkg::err_info_t exp_err;
    logic                     exp_armed;            // an error record is expected
    logic                     err_seen;
    logic                     inj_armed;            // corrupt the next read of inj_line
    lpbk_test_pkg::line_idx_t inj_line;
    int                       inj_word;
    lpbk_bus_pkg::word_t      inj_mask;
    lpbk_bus_pkg::seed_t      inj_seed;             // recorded seed of the corrupted line
    logic [`LPBK_LINES-1:0]   rd_seen;              // lines that got a read
    int                       wr_checked;
    string                    cur_name;
    logic [31:0]              lcg_state = 32'hd75a0872;
    int                       cycle = 0;
    int                       fails = 0;
    int                       start_fails;
    int                       tests_run = 0;
    int                       tests_bad = 0;

    lpbk_coherency i_lpbk_coherency (
        .Clk_16UI (Clk_16UI),
        .arst_n   (arst_n),
        .cfg      (cfg),
        .wr_req   (wr_req),
        .wr_sent  (wr_sent),
        .rd_req   (rd_req),
        .rd_sent  (rd_sent),
        .rd_rsp   (rd_rsp),
        .wr_rsp   (wr_rsp),
        .err      (err)
    );

    initial
    begin
        Clk_16UI = 1'b0;
        forever #4 Clk_16UI = ~Clk_16UI;           // 8 ns period
    end

    // **************************************************
    // reference model
    // **************************************************
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // line as the engine writes it
    function automatic lpbk_bus_pkg::line_t build_line(input lpbk_bus_pkg::word_t dst,
        input lpbk_bus_pkg::addr_t addr, input lpbk_bus_pkg::seed_t seed);
        lpbk_bus_pkg::word_t key;
        key = dst ^ lpbk_bus_pkg::word_t'(addr);
        return {{4{~seed}}, key, {4{seed}}, key};
    endfunction

    // error record for a returned line, first differing word wins
    function automatic lpbk_test_pkg::err_info_t ref_err(input lpbk_bus_pkg::word_t dst,
        input lpbk_bus_pkg::addr_t addr, input lpbk_bus_pkg::line_t data,
        input lpbk_bus_pkg::seed_t seed);
        lpbk_test_pkg::err_info_t r;
        lpbk_bus_pkg::word_t      key;
        lpbk_bus_pkg::word_t      w [4];
        logic                     own;
        int                       i;
        key = dst ^ lpbk_bus_pkg::word_t'(addr);
        own = addr[`LPBK_OWN_BIT];                  // fpga owned
        for (i = 0; i < 4; i++)
            w[i] = data[i*`LPBK_WORD_W +: `LPBK_WORD_W];
        r       = '0;
        r.valid = 1'b1;
        r.code  = own ? 6'b001000 : 6'b011000;
        r.addr  = key;
        if (own && w[1] != {4{seed}})
        begin
            r.received = w[1];
            r.expected = {4{seed}};
        end
        else if (own && w[3] != {4{~seed}})
        begin
            r.received = w[3];
            r.expected = {4{~seed}};
        end
        else if (w[0] != key)
        begin
            r.received = w[0];
            r.expected = key;
        end
        else if (w[2] != key)
        begin
            r.received = w[2];
            r.expected = key;
        end
        else
            r = '0;                                 // clean line
        return r;
    endfunction

    task automatic check_err(input string name, input lpbk_test_pkg::err_info_t exp,
                             input lpbk_test_pkg::err_info_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: err expected v%b c%b a%h r%h e%h actual v%b c%b a%h r%h e%h",
                     name, exp.valid, exp.code, exp.addr, exp.received, exp.expected,
                     act.valid, act.code, act.addr, act.received, act.expected);
            fails++;
        end
    endtask

    task automatic check_line(input string name, input lpbk_bus_pkg::line_t exp,
                              input lpbk_bus_pkg::line_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: line expected %h actual %h", name, exp, act);
            fails++;
        end
    endtask

    task automatic check_tag(input string name, input lpbk_bus_pkg::tag_t exp,
                             input lpbk_bus_pkg::tag_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: tag expected %h actual %h", name, exp, act);
            fails++;
        end
    endtask

    // **************************************************
    // memory model and compare process
    // **************************************************
    always @(posedge Clk_16UI)
    begin : mem_model
        lpbk_test_pkg::line_idx_t idx;
        lpbk_bus_pkg::line_t      data;
        logic [31:0]              rnd;
        if (!arst_n)
        begin
            rd_pipe[0] = '0;
            rd_pipe[1] = '0;
            wr_pipe[0] = '0;
            wr_pipe[1] = '0;
            rd_rsp    <= '0;
            wr_rsp    <= '0;
        end
        else
        begin
            rd_rsp    <= rd_pipe[1];                // answer 3 cycles after the request
            wr_rsp    <= wr_pipe[1];
            rd_pipe[1] = rd_pipe[0];
            wr_pipe[1] = wr_pipe[0];
            rd_pipe[0] = '0;
            wr_pipe[0] = '0;
            if (wr_req.en && wr_sent)
            begin
                idx = wr_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2];
                check_line(cur_name, build_line(cfg.dst_addr, wr_req.addr,
                           wr_req.data[`LPBK_WORD_W +: 8]), wr_req.data);
                check_tag(cur_name, lpbk_bus_pkg::tag_t'(idx), wr_req.tag);
                mem[idx]      = wr_req.data;
                seed_rec[idx] = wr_req.data[`LPBK_WORD_W +: 8];
                wr_checked++;
                wr_pipe[0].valid = 1'b1;
                wr_pipe[0].addr  = wr_req.addr;
            end
            if (rd_req.en && rd_sent)
            begin
                idx = rd_req.addr[`LPBK_OWN_BIT +: `LPBK_LINES_LOG2];
                check_tag(cur_name, lpbk_bus_pkg::tag_t'(idx), rd_req.tag);
                if (rd_req.addr[`LPBK_OWN_BIT])
                    data = mem[idx];                // fpga owned, data written back
                else
                begin
                    rnd  = lcg_next();
                    data = build_line(cfg.dst_addr, rd_req.addr, rnd[31:24]);
                end
                if (inj_armed && idx == inj_line)
                begin
                    data[inj_word*`LPBK_WORD_W +: `LPBK_WORD_W] ^= inj_mask;
                    exp_err   = ref_err(cfg.dst_addr, rd_req.addr, data, seed_rec[idx]);
                    inj_seed  = seed_rec[idx];
                    exp_armed = 1'b1;
                    inj_armed = 1'b0;
                end
                rd_seen[idx]     = 1'b1;
                rd_pipe[0].valid = 1'b1;
                rd_pipe[0].addr  = rd_req.addr;
                rd_pipe[0].data  = data;
            end
            if (err.valid && !err_seen)
            begin
                err_seen = 1'b1;
                if (exp_armed)
                    check_err(cur_name, exp_err, err);
                else
                begin
                    $display("%s: error record raised with code %b on a clean run",
                             cur_name, err.code);
                    fails++;
                end
            end
        end
    end

    always @(posedge Clk_16UI)
    begin
        cycle++;
        if (cycle >= max_cycles)
        begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("test failed");
            $finish;
        end
    end

    // **************************************************
    // test sequencing
    // **************************************************
    // stop issuing, drain, then hold reset and set up the next test
    task automatic start_test(input string name, input lpbk_test_pkg::line_cnt_t num,
                              input logic inject, input int word, input logic fpga_line);
        logic [31:0] rnd;
        @(posedge Clk_16UI);
        cfg.go <= 1'b0;
        repeat (6) @(posedge Clk_16UI);             // outstanding responses land
        arst_n <= 1'b0;
        @(posedge Clk_16UI);
        rnd           = lcg_next();
        cur_name      = name;
        start_fails   = fails;
        err_seen      = 1'b0;
        exp_armed     = 1'b0;
        rd_seen       = '0;
        wr_checked    = 0;
        inj_armed     = inject;
        inj_word      = word;
        inj_line      = {rnd[30:29], fpga_line};    // odd lines are fpga owned
        inj_mask      = lcg_next() | 32'h1;         // never a null corruption
        cfg.dst_addr <= lcg_next();
        cfg.num_lines <= num;
    endtask

    task automatic release_run();
        repeat (2) @(posedge Clk_16UI);             // reset low 3 cycles in all
        arst_n <= 1'b1;
        @(posedge Clk_16UI);
        cfg.go <= 1'b1;
    endtask

    task automatic wait_err(input int limit);
        int n;
        n = 0;
        while (!err_seen && n < limit)
        begin
            @(negedge Clk_16UI);
            n++;
        end
        if (!err_seen)
        begin
            $display("%s: no error record within %0d cycles", cur_name, limit);
            fails++;
        end
    endtask

    task automatic finish_test();
        @(negedge Clk_16UI);
        tests_run++;
        if (fails == start_fails)
            $display("%s: ok", cur_name);
        else
        begin
            tests_bad++;
            $display("%s: FAILED with %0d errors", cur_name, fails - start_fails);
        end
    endtask

    initial
    begin
        arst_n      = 1'b0;
        cfg         = '0;
        wr_sent     = 1'b1;                         // model takes every request
        rd_sent     = 1'b1;
        rd_rsp      = '0;
        wr_rsp      = '0;
        exp_err     = '0;
        exp_armed   = 1'b0;
        err_seen    = 1'b0;
        inj_armed   = 1'b0;
        inj_line    = '0;
        inj_word    = 0;
        inj_mask    = '0;
        inj_seed    = '0;
        rd_seen     = '0;
        wr_checked  = 0;
        cur_name    = "idle";
        start_fails = 0;

        start_test("clean_run", 8, 1'b0, 0, 1'b0);
        release_run();
        repeat (300) @(posedge Clk_16UI);
        @(negedge Clk_16UI);
        check_err(cur_name, '0, err);
        for (int i = 0; i < `LPBK_LINES; i++)
        begin
            if (!rd_seen[i])
            begin
                $display("%s: line %0d never received a read", cur_name, i);
                fails++;
            end
        end
        finish_test();

        start_test("write_lines", 8, 1'b0, 0, 1'b0);
        release_run();
        repeat (100) @(posedge Clk_16UI);
        @(negedge Clk_16UI);
        if (wr_checked == 0)
        begin
            $display("%s: no write was accepted", cur_name);
            fails++;
        end
        finish_test();

        start_test("cpu_word0_error", 8, 1'b1, 0, 1'b0);
        release_run();
        wait_err(200);
        if (err_seen && err.code !== 6'b011000)
        begin
            $display("Mismatch %s: code expected %b actual %b", cur_name, 6'b011000,
                     err.code);
            fails++;
        end
        finish_test();

        start_test("fpga_word1_error", 8, 1'b1, 1, 1'b1);
        release_run();
        wait_err(200);
        if (err_seen && err.expected !== {4{inj_seed}})
        begin
            $display("Mismatch %s: seed word expected %h actual %h", cur_name,
                     {4{inj_seed}}, err.expected);
            fails++;
        end
        finish_test();

        start_test("line_count_error", 1, 1'b0, 0, 1'b0);
        exp_err       = '0;                         // only valid and code are set
        exp_err.valid = 1'b1;
        exp_err.code  = 6'b100000;
        exp_armed     = 1'b1;
        release_run();
        wait_err(20);
        finish_test();

        fails = fails + i_lpbk_coherency.i_lpbk_coherency_chk.assert_fails;
        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_bad, fails);
        if (fails == 0 && tests_bad == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+design
design/lpbk_bus_pkg.sv
design/lpbk_test_pkg.sv
design/line_tracker.sv
design/req_issuer.sv
design/seed_ram.sv
design/rd_checker.sv
design/lpbk_coherency.sv
test/lpbk_coherency_chk.sv
test/tb_lpbk_coherency.sv

// ==== Bender.yml ====
package:
  name: lpbk_coherency

sources:
  - include_dirs:
      - design
    files:
      - design/lpbk_bus_pkg.sv
      - design/lpbk_test_pkg.sv
      - design/line_tracker.sv
      - design/req_issuer.sv
      - design/seed_ram.sv
      - design/rd_checker.sv
      - design/lpbk_coherency.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/lpbk_coherency_chk.sv
      - test/tb_lpbk_coherency.sv
